// File: prog_fetch.f
hw/rv_isa_pkg.sv
hw/prog_mem_pkg.sv
hw/fetch_if.sv
hw/prog_mem.sv
hw/inst_decoder.sv
hw/prog_fetch_top.sv
testbench/prog_fetch_checker.sv
testbench/prog_fetch_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the program fetch testbench with Verilator, run it, and check the log

LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --timescale 1ns/100ps \
  --top-module prog_fetch_tb \
  -f prog_fetch.f \
  --Mdir obj_dir \
  -o prog_fetch_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/prog_fetch_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed, see $LOG"
exit 1

// File: testbench/prog_fetch_tb.sv
`default_nettype none

module prog_fetch_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import rv_isa_pkg::*;
  import prog_mem_pkg::*;

  localparam int mem_words = MEM_WORDS_DEFAULT;
  localparam int addr_w = $clog2(mem_words);
  localparam int wait_limit = 20;

  // One word per format plus SUB, SRAI and negative B and J offsets
  localparam logic [31:0] fmt_words [13] = '{
    32'h003100B3, 32'h407302B3, 32'hFFB58513, 32'h4036D613, 32'h00812703,
    32'hFEF12E23, 32'hFE2088E3, 32'h123451B7, 32'hFFFFF217, 32'hFF9FF0EF,
    32'h00008067, 32'h0FF0000F, 32'h00000073
  };

  // Unknown opcode, branch funct3 2, MUL funct7, SLLI alt funct7, load f3 7, store f3 3
  localparam logic [31:0] bad_words [6] = '{
    32'h0000007F, 32'h00002063, 32'h02000033, 32'h40001013, 32'h00007003, 32'h00003023
  };

  localparam logic [6:0] known_opcodes [11] = '{
    OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LOAD,
    OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_MISC_MEM, OPC_SYSTEM
  };

  logic                  fpga_clk1_50;
  logic                  rst_n;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [APB_ADDR_W-1:0] paddr;
  logic [APB_DATA_W-1:0] pwdata;
  logic [APB_STRB_W-1:0] pstrb;
  logic [APB_DATA_W-1:0] prdata;
  logic                  pready;
  logic                  pslverr;
  logic                  fetch_valid;
  logic [addr_w-1:0]     fetch_addr;
  logic                  dec_valid;
  decoded_inst_s         dec_inst;

  // Expected memory contents
  logic [31:0] image [mem_words];
  logic [31:0] rng_state = 32'd30;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          failed = 0;

  prog_fetch_top #(
    .mem_words (mem_words)
  ) prog_fetch_top_i (.*);

  bind prog_fetch_top prog_fetch_checker checker_i (.*);

  initial begin
    fpga_clk1_50 = 1'b0;
    forever #20 fpga_clk1_50 = ~fpga_clk1_50;
  end

  function automatic int total_errors();
    return errors + prog_fetch_top_i.checker_i.fail_count;
  endfunction

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Expected decode from the RV32I encoding rules
  function automatic decoded_inst_s ref_decode(input logic [31:0] w);
    decoded_inst_s d;
    logic [6:0]    op;
    logic [2:0]    f3;
    logic [6:0]    f7;
    logic          shift;
    op = w[6:0];
    f3 = w[14:12];
    f7 = w[31:25];
    shift = (op == OPC_OP_IMM) && (f3 == 3'd1 || f3 == 3'd5);
    d = '0;
    d.rd = w[11:7];
    d.rs1 = w[19:15];
    d.rs2 = w[24:20];
    d.funct3 = f3;
    case (op)
      OPC_OP:                                                   d.format = FMT_R;
      OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_MISC_MEM, OPC_SYSTEM: d.format = FMT_I;
      OPC_STORE:                                                d.format = FMT_S;
      OPC_BRANCH:                                               d.format = FMT_B;
      OPC_LUI, OPC_AUIPC:                                       d.format = FMT_U;
      OPC_JAL:                                                  d.format = FMT_J;
      default:                                                  d.format = FMT_ILLEGAL;
    endcase
    case (d.format)
      FMT_I:   d.imm = 32'($signed(w[31:20]));
      FMT_S:   d.imm = 32'($signed({w[31:25], w[11:7]}));
      FMT_B:   d.imm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
      FMT_U:   d.imm = {w[31:12], 12'h000};
      FMT_J:   d.imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
      default: d.imm = '0;
    endcase
    d.illegal = (d.format == FMT_ILLEGAL) ||
                (op == OPC_BRANCH && (f3 == 3'd2 || f3 == 3'd3)) ||
                (op == OPC_LOAD && (f3 == 3'd3 || f3 >= 3'd6)) ||
                (op == OPC_STORE && f3 > 3'd2) ||
                ((op == OPC_OP || shift) && f7 != 7'h00 &&
                 !(f7 == 7'h20 && (f3 == 3'd5 || (op == OPC_OP && f3 == 3'd0))));
    if (d.illegal) begin
      d.format = FMT_ILLEGAL;
    end
    return d;
  endfunction

  task automatic next_cycle();
    @(posedge fpga_clk1_50);
    #2;
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      $display("error %s: expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  // Setup phase then access phase until pready
  task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, output logic [31:0] rdata, output logic err);
    int n;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = wr;
    paddr = addr;
    pwdata = data;
    pstrb = strb;
    next_cycle();
    penable = 1'b1;
    @(negedge fpga_clk1_50);
    n = 0;
    while (!pready && n < wait_limit) begin
      @(negedge fpga_clk1_50);
      n++;
    end
    if (!pready) begin
      $display("APB transfer to address %h never saw pready", addr);
      errors++;
    end
    rdata = prdata;
    err = pslverr;
    next_cycle();
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_write(input int idx, input logic [31:0] data, input logic [3:0] strb);
    logic [31:0] rd_data;
    logic        err;
    apb_xfer(1'b1, idx * 4, data, strb, rd_data, err);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        image[idx][b*8 +: 8] = data[b*8 +: 8];
      end
    end
    check_word("apb_write_slverr", 32'd0, 32'(err));
  endtask

  // Back-to-back requests with results collected in order
  task automatic fetch_run(input int base, input int count, input string name);
    int issued;
    int got;
    int n;
    issued = 0;
    got = 0;
    n = 0;
    while (got < count && n < count + wait_limit) begin
      fetch_valid = (issued < count);
      fetch_addr = addr_w'(base + issued);
      if (issued < count) begin
        issued++;
      end
      @(negedge fpga_clk1_50);
      if (dec_valid) begin
        checks++;
        if (dec_inst !== ref_decode(image[base + got])) begin
          $display("error %s word %h: expected %h actual %h", name, image[base + got],
                   ref_decode(image[base + got]), dec_inst);
          errors++;
        end
        got++;
      end
      next_cycle();
      n++;
    end
    fetch_valid = 1'b0;
    if (got < count) begin
      $display("%s timed out with %0d of %0d decoded words", name, got, count);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int mark);
    tests++;
    if (total_errors() == mark) begin
      $display("test %s: pass", name);
    end else begin
      failed++;
      $display("test %s: %0d failures", name, total_errors() - mark);
    end
  endtask

  initial begin
    logic [31:0] rd_data;
    logic [31:0] w;
    logic        err;
    int          mark;
    rst_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    pstrb = '0;
    fetch_valid = 1'b0;
    fetch_addr = '0;
    repeat (5) @(posedge fpga_clk1_50);
    #2;
    rst_n = 1'b1;
    next_cycle();

    mark = total_errors();
    for (int i = 0; i < 4; i++) begin
      apb_write(i, next_random(), 4'hf);
    end
    apb_write(0, 32'hDDDDDDDD, 4'b1001);
    apb_write(1, 32'hAAAAAAAA, 4'b0001);
    apb_write(2, 32'hBBBBBBBB, 4'b0100);
    apb_write(3, 32'hCCCCCCCC, 4'b1010);
    for (int i = 0; i < 4; i++) begin
      apb_xfer(1'b0, i * 4, '0, '0, rd_data, err);
      check_word("byte_lane", image[i], rd_data);
    end
    finish_test("byte_lane", mark);

    mark = total_errors();
    apb_xfer(1'b1, 32'(mem_words * 4), 32'hDEADBEEF, 4'hf, rd_data, err);
    check_word("out_of_range_write", 32'd1, 32'(err));
    apb_xfer(1'b0, 32'(mem_words * 4 + 64), '0, '0, rd_data, err);
    check_word("out_of_range_read", 32'd1, 32'(err));
    apb_xfer(1'b0, 32'd0, '0, '0, rd_data, err);
    check_word("in_range_slverr", 32'd0, 32'(err));
    check_word("in_range_data", image[0], rd_data);
    finish_test("out_of_range", mark);

    mark = total_errors();
    for (int i = 0; i < 13; i++) begin
      apb_write(16 + i, fmt_words[i], 4'hf);
    end
    fetch_run(16, 13, "format_decode");
    finish_test("format_decode", mark);

    // Every other random word gets a real opcode to reach the funct checks
    mark = total_errors();
    for (int i = 0; i < 6; i++) begin
      apb_write(64 + i, bad_words[i], 4'hf);
    end
    for (int i = 0; i < 200; i++) begin
      w = next_random();
      if (i % 2 == 0) begin
        w[6:0] = known_opcodes[int'(w[31:28]) % 11];
      end
      apb_write(70 + i, w, 4'hf);
    end
    fetch_run(64, 206, "illegal_random");
    finish_test("illegal_random", mark);

    mark = total_errors();
    fetch_run(16, 13, "pipelined_fetch");
    // Reset lands with a decoded word and an APB error in flight
    fetch_valid = 1'b1;
    fetch_addr = addr_w'(16);
    next_cycle();
    psel = 1'b1;
    pwrite = 1'b0;
    paddr = 32'(mem_words * 4);
    next_cycle();
    fetch_valid = 1'b0;
    psel = 1'b0;
    rst_n = 1'b0;
    repeat (5) next_cycle();
    rst_n = 1'b1;
    next_cycle();
    fetch_run(64, 40, "fetch_after_reset");
    finish_test("pipelined_reset", mark);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed, checks, total_errors());
    if (total_errors() == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/prog_fetch_checker.sv
`default_nettype none

module prog_fetch_checker (
  input logic                      fpga_clk1_50,
  input logic                      rst_n,
  input logic                      psel,
  input logic                      penable,
  input logic                      pready,
  input logic                      pslverr,
  input logic                      fetch_valid,
  input logic                      dec_valid,
  input rv_isa_pkg::decoded_inst_s dec_inst
);

  timeunit 1ns;
  timeprecision 100ps;

  import rv_isa_pkg::*;

  int pready_fails = 0;
  int slverr_fails = 0;
  int illegal_fails = 0;
  int latency_fails = 0;
  int reset_fails = 0;
  int fail_count;

  assign fail_count = pready_fails + slverr_fails + illegal_fails + latency_fails + reset_fails;

  // No wait states on the load port
  pready_in_access: assert property (@(posedge fpga_clk1_50) disable iff (!rst_n)
    (psel && penable) |-> pready)
  else begin
    $error("pready low in an APB access phase");
    pready_fails++;
  end

  slverr_in_access: assert property (@(posedge fpga_clk1_50) disable iff (!rst_n)
    pslverr |-> (psel && penable))
  else begin
    $error("pslverr high outside an APB access phase");
    slverr_fails++;
  end

  illegal_matches_format: assert property (@(posedge fpga_clk1_50) disable iff (!rst_n)
    dec_valid |-> (dec_inst.illegal == (dec_inst.format == FMT_ILLEGAL)))
  else begin
    $error("illegal flag and FMT_ILLEGAL disagree");
    illegal_fails++;
  end

  // Memory read register plus decoder register
  two_cycle_latency: assert property (@(posedge fpga_clk1_50) disable iff (!rst_n)
    dec_valid == $past(fetch_valid, 2))
  else begin
    $error("dec_valid does not follow fetch_valid by two cycles");
    latency_fails++;
  end

  quiet_in_reset: assert property (@(posedge fpga_clk1_50)
    (!rst_n || $past(!rst_n) || $past(!rst_n, 2)) |-> (!dec_valid && !pslverr))
  else begin
    $error("dec_valid or pslverr high in or right after reset");
    reset_fails++;
  end

endmodule

`default_nettype wire

// File: hw/prog_fetch_top.sv
`default_nettype none

module prog_fetch_top #(
  parameter int mem_words = prog_mem_pkg::MEM_WORDS_DEFAULT
) (
  input  logic                                fpga_clk1_50,
  input  logic                                rst_n,

  // APB load port
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [prog_mem_pkg::APB_ADDR_W-1:0] paddr,
  input  logic [prog_mem_pkg::APB_DATA_W-1:0] pwdata,
  input  logic [prog_mem_pkg::APB_STRB_W-1:0] pstrb,
  output logic [prog_mem_pkg::APB_DATA_W-1:0] prdata,
  output logic                                pready,
  output logic                                pslverr,

  // Fetch request, word index
  input  logic                                fetch_valid,
  input  logic [$clog2(mem_words)-1:0]        fetch_addr,

  // Decoded instruction, two cycles after the request
  output logic                                dec_valid,
  output rv_isa_pkg::decoded_inst_s           dec_inst
);

  fetch_if #(
    .mem_words (mem_words)
  ) fetch_bus ();

  prog_mem #(
    .mem_words (mem_words)
  ) mem (
    .fpga_clk1_50 (fpga_clk1_50),
    .rst_n        (rst_n),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .pstrb        (pstrb),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .fetch_valid  (fetch_valid),
    .fetch_addr   (fetch_addr),
    .fetch        (fetch_bus.source)
  );

  inst_decoder dec (
    .fpga_clk1_50 (fpga_clk1_50),
    .rst_n        (rst_n),
    .fetch        (fetch_bus.sink),
    .dec_valid    (dec_valid),
    .dec_inst     (dec_inst)
  );

endmodule

`default_nettype wire

// File: hw/inst_decoder.sv
`default_nettype none

module inst_decoder (
  input  logic                        fpga_clk1_50,
  input  logic                        rst_n,
  fetch_if.sink                       fetch,
  output logic                        dec_valid,
  output rv_isa_pkg::decoded_inst_s   dec_inst
);

  import rv_isa_pkg::*;

  logic [31:0]   inst;
  logic [6:0]    opcode;
  logic [6:0]    funct7;
  logic [2:0]    funct3;
  inst_format_e  base_fmt;
  logic [31:0]   imm;
  logic          bad_opcode;
  logic          bad_funct3;
  logic          bad_funct7;
  logic          alt_ok;
  decoded_inst_s dec_next;

  assign inst   = fetch.word;
  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // Format from the opcode alone, SYSTEM falls in with I
  always_comb begin
    case (opcode)
      OPC_LUI,
      OPC_AUIPC:    base_fmt = FMT_U;
      OPC_JAL:      base_fmt = FMT_J;
      OPC_JALR,
      OPC_LOAD,
      OPC_OP_IMM,
      OPC_MISC_MEM,
      OPC_SYSTEM:   base_fmt = FMT_I;
      OPC_BRANCH:   base_fmt = FMT_B;
      OPC_STORE:    base_fmt = FMT_S;
      OPC_OP:       base_fmt = FMT_R;
      default:      base_fmt = FMT_ILLEGAL;
    endcase
  end

  assign bad_opcode = (base_fmt == FMT_ILLEGAL);

  // Immediate follows the opcode format even when funct bits are bad
  always_comb begin
    case (base_fmt)
      FMT_I:   imm = {{20{inst[31]}}, inst[31:20]};
      FMT_S:   imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      FMT_B:   imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                      inst[11:8], 1'b0};
      FMT_U:   imm = {inst[31:12], 12'b0};
      FMT_J:   imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                      inst[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

  // 0100000 only for SUB, SRA and SRAI
  assign alt_ok = (funct3 == F3_SR) ||
                  (opcode == OPC_OP && funct3 == F3_ADD_SUB);

  always_comb begin
    bad_funct3 = 1'b0;
    bad_funct7 = 1'b0;
    case (opcode)
      OPC_BRANCH: begin
        bad_funct3 = (funct3 == F3_BR_RSV0) || (funct3 == F3_BR_RSV1);
      end
      OPC_LOAD: begin
        bad_funct3 = (funct3 == F3_LD_RSV0) || (funct3 == F3_LD_RSV1) ||
                     (funct3 == F3_LD_RSV2);
      end
      OPC_STORE: begin
        bad_funct3 = (funct3 > F3_SW);
      end
      OPC_OP: begin
        bad_funct7 = !((funct7 == F7_BASE) || (funct7 == F7_ALT && alt_ok));
      end
      OPC_OP_IMM: begin
        // Only the shifts carry a funct7
        if (funct3 == F3_SLL || funct3 == F3_SR) begin
          bad_funct7 = !((funct7 == F7_BASE) || (funct7 == F7_ALT && alt_ok));
        end
      end
      default: begin
        bad_funct3 = 1'b0;
        bad_funct7 = 1'b0;
      end
    endcase
  end

  always_comb begin
    dec_next.illegal = bad_opcode || bad_funct3 || bad_funct7;
    dec_next.format  = dec_next.illegal ? FMT_ILLEGAL : base_fmt;
    dec_next.rd      = inst[11:7];
    dec_next.rs1     = inst[19:15];
    dec_next.rs2     = inst[24:20];
    dec_next.funct3  = funct3;
    dec_next.imm     = imm;
  end

  always_ff @(posedge fpga_clk1_50 or negedge rst_n) begin
    if (!rst_n) begin
      fetch.fetch_seen <= 1'b0;
    end else begin
      fetch.fetch_seen <= fetch.word_valid;
    end
  end

  // Holds the last decode between valid words
  always_ff @(posedge fpga_clk1_50) begin
    if (fetch.word_valid) begin
      dec_inst <= dec_next;
    end
  end

  assign dec_valid = fetch.fetch_seen;

endmodule

`default_nettype wire

// File: hw/prog_mem.sv
`default_nettype none

module prog_mem #(
  parameter int mem_words = prog_mem_pkg::MEM_WORDS_DEFAULT
) (
  input  logic                                fpga_clk1_50,
  input  logic                                rst_n,

  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [prog_mem_pkg::APB_ADDR_W-1:0] paddr,
  input  logic [prog_mem_pkg::APB_DATA_W-1:0] pwdata,
  input  logic [prog_mem_pkg::APB_STRB_W-1:0] pstrb,
  output logic [prog_mem_pkg::APB_DATA_W-1:0] prdata,
  output logic                                pready,
  output logic                                pslverr,

  input  logic                                fetch_valid,
  input  logic [$clog2(mem_words)-1:0]        fetch_addr,
  fetch_if.source                             fetch
);

  import prog_mem_pkg::*;

  localparam int addr_w = $clog2(mem_words);

  // One array per byte lane, lane 0 holds bits 7:0
  logic [7:0] mem_array_0 [mem_words];
  logic [7:0] mem_array_1 [mem_words];
  logic [7:0] mem_array_2 [mem_words];
  logic [7:0] mem_array_3 [mem_words];

  logic [addr_w-1:0] apb_idx;
  logic              apb_oor;
  logic              setup_phase;
  logic              access_phase;
  logic              apb_wr;

  assign apb_idx      = paddr[addr_w+1:2];
  assign apb_oor      = paddr[APB_ADDR_W-1:2] >= (APB_ADDR_W-2)'(mem_words);
  assign setup_phase  = psel && !penable;
  assign access_phase = psel && penable;
  assign apb_wr       = access_phase && pwrite && !apb_oor;

  // No wait states
  assign pready = access_phase;

  // Byte-enabled writes at the access-phase edge
  always_ff @(posedge fpga_clk1_50) begin
    if (apb_wr) begin
      if (pstrb[0]) begin
        mem_array_0[apb_idx] <= pwdata[7:0];
      end
      if (pstrb[1]) begin
        mem_array_1[apb_idx] <= pwdata[15:8];
      end
      if (pstrb[2]) begin
        mem_array_2[apb_idx] <= pwdata[23:16];
      end
      if (pstrb[3]) begin
        mem_array_3[apb_idx] <= pwdata[31:24];
      end
    end
  end

  // Read data captured in setup so it is ready for the access phase
  always_ff @(posedge fpga_clk1_50) begin
    if (setup_phase && !pwrite) begin
      if (apb_oor) begin
        prdata <= '0;
      end else begin
        prdata <= {mem_array_3[apb_idx], mem_array_2[apb_idx],
                   mem_array_1[apb_idx], mem_array_0[apb_idx]};
      end
    end
  end

  // Error flag lives for the access phase only
  always_ff @(posedge fpga_clk1_50 or negedge rst_n) begin
    if (!rst_n) begin
      pslverr <= 1'b0;
    end else begin
      pslverr <= setup_phase && apb_oor;
    end
  end

  // Fetch port, a write in the same cycle is not seen until the next read
  always_ff @(posedge fpga_clk1_50) begin
    if (fetch_valid) begin
      fetch.word      <= {mem_array_3[fetch_addr], mem_array_2[fetch_addr],
                          mem_array_1[fetch_addr], mem_array_0[fetch_addr]};
      fetch.word_addr <= fetch_addr;
    end
  end

  always_ff @(posedge fpga_clk1_50 or negedge rst_n) begin
    if (!rst_n) begin
      fetch.word_valid <= 1'b0;
    end else begin
      fetch.word_valid <= fetch_valid;
    end
  end

endmodule

`default_nettype wire

// File: hw/fetch_if.sv
`default_nettype none

interface fetch_if #(
  parameter int mem_words = prog_mem_pkg::MEM_WORDS_DEFAULT
);

  // Written by the memory read register
  logic                         word_valid;
  logic [31:0]                  word;
  // Word index that goes with word, for tracing
  logic [$clog2(mem_words)-1:0] word_addr;

  // Decoder stage occupancy, one cycle behind word_valid
  logic                         fetch_seen;

  modport source (
    output word_valid,
    output word,
    output word_addr
  );

  modport sink (
    input  word_valid,
    input  word,
    input  word_addr,
    output fetch_seen
  );

endinterface

`default_nettype wire

// File: hw/prog_mem_pkg.sv
`default_nettype none

package prog_mem_pkg;

  // Program memory depth in 32-bit words
  localparam int MEM_WORDS_DEFAULT = 1024;

  // APB load port, byte addressed
  localparam int APB_ADDR_W = 32;
  localparam int APB_DATA_W = 32;

  // One strobe per byte lane
  localparam int APB_STRB_W = APB_DATA_W / 8;

endpackage

`default_nettype wire

// File: hw/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // Base opcodes, bits 6:0 of the instruction
  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

  // funct3 values that the decoder checks against
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SR      = 3'b101;

  // Branch funct3 values 2 and 3 have no instruction
  localparam logic [2:0] F3_BR_RSV0 = 3'b010;
  localparam logic [2:0] F3_BR_RSV1 = 3'b011;

  // Loads know LB, LH, LW, LBU and LHU only
  localparam logic [2:0] F3_LD_RSV0 = 3'b011;
  localparam logic [2:0] F3_LD_RSV1 = 3'b110;
  localparam logic [2:0] F3_LD_RSV2 = 3'b111;

  // Widest store is SW
  localparam logic [2:0] F3_SW = 3'b010;

  // funct7 for plain ops and for SUB, SRA and SRAI
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  typedef enum logic [2:0] {
    FMT_R,
    FMT_I,
    FMT_S,
    FMT_B,
    FMT_U,
    FMT_J,
    FMT_ILLEGAL
  } inst_format_e;

  // Register fields are raw bit slices, whatever the format
  typedef struct packed {
    inst_format_e format;
    logic [4:0]   rd;
    logic [4:0]   rs1;
    logic [4:0]   rs2;
    logic [2:0]   funct3;
    logic [31:0]  imm;
    logic         illegal;
  } decoded_inst_s;

endpackage

`default_nettype wire
